// File: src/rvPkg.sv
package rvPkg;

	localparam int xlen = 32;

	// Major opcodes
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opAuipc = 7'b0010111;
	localparam logic [6:0] opOp = 7'b0110011;
	localparam logic [6:0] opOpImm = 7'b0010011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;
	localparam logic [6:0] opSystem = 7'b1110011;

	// Top bit selects a signed compare for the less flag
	typedef enum logic [3:0] {
		aluAdd = 4'b1000,
		aluSub = 4'b1100,
		aluSubU = 4'b0100,
		aluAnd = 4'b1001,
		aluXor = 4'b1010,
		aluOr = 4'b1011,
		aluSll = 4'b1101,
		aluSrl = 4'b1110,
		aluSra = 4'b1111
	} aluOp_t;

	typedef enum logic [1:0] {srcZero = 2'b01, srcPc = 2'b10, srcRs1 = 2'b11} srcA_t;
	typedef enum logic [1:0] {srcRs2 = 2'b00, srcImm = 2'b10, srcFour = 2'b11} srcB_t;
	typedef enum logic [1:0] {wbAlu = 2'b01, wbLess = 2'b10, wbLoad = 2'b11} wbSel_t;

	typedef enum logic [2:0] {
		ldWord = 3'b000,
		ldHalf = 3'b001,
		ldByte = 3'b010,
		ldHalfU = 3'b011,
		ldByteU = 3'b100,
		ldNone = 3'b111 // Not a load
	} ldKind_t;

	typedef enum logic [1:0] {stNone, stWord, stHalf, stByte} stKind_t;
	typedef enum logic [2:0] {brNone, brEq, brNe, brLt, brGe} brKind_t;

	typedef struct packed {
		logic regWrite;
		wbSel_t wbSel;
		stKind_t stKind;
		ldKind_t ldKind;
		srcA_t srcA;
		srcB_t srcB;
		aluOp_t aluOp;
		brKind_t brKind;
		logic jal;
		logic jalr;
	} ctrlWord_t;

	typedef enum logic [1:0] {stFetch, stExec, stMem, stWrite} coreState_t;

endpackage

// File: src/riscvDecode.sv
`timescale 1ns/1ps

module riscvDecode
	import rvPkg::*;
(
	input logic [31:0] instr,
	input logic hold,
	output ctrlWord_t ctrl,
	output logic [31:0] imm
);

	logic [2:0] funct3;
	logic knownOp;
	logic [31:0] uImm;
	logic [31:0] iImm;
	logic [31:0] sImm;
	logic [31:0] bImm;
	logic [31:0] jImm;
	logic [31:0] shImm;

	assign funct3 = instr[14:12];

	assign uImm = {instr[31:12], 12'b0};
	assign iImm = {{20{instr[31]}}, instr[31:20]};
	assign sImm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	assign shImm = {27'b0, instr[24:20]};

	// Shared by register and immediate ALU forms
	function automatic aluOp_t aluSelect(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? aluSub : aluAdd;
			3'b001: return aluSll;
			3'b010: return aluSub;
			3'b011: return aluSubU;
			3'b100: return aluXor;
			3'b101: return alt ? aluSra : aluSrl;
			3'b110: return aluOr;
			default: return aluAnd;
		endcase
	endfunction

	always_comb
	begin
		knownOp = 1'b1;
		ctrl = '{regWrite: 1'b0, wbSel: wbAlu, stKind: stNone, ldKind: ldNone,
			srcA: srcRs1, srcB: srcImm, aluOp: aluAdd, brKind: brNone,
			jal: 1'b0, jalr: 1'b0};
		imm = iImm;
		case (instr[6:0])
			opLoad:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = wbLoad;
				case (funct3)
					3'b010: ctrl.ldKind = ldWord;
					3'b001: ctrl.ldKind = ldHalf;
					3'b000: ctrl.ldKind = ldByte;
					3'b101: ctrl.ldKind = ldHalfU;
					3'b100: ctrl.ldKind = ldByteU;
					default: ctrl.ldKind = ldNone;
				endcase
			end
			opStore:
			begin
				imm = sImm;
				case (funct3)
					3'b010: ctrl.stKind = stWord;
					3'b001: ctrl.stKind = stHalf;
					3'b000: ctrl.stKind = stByte;
					default: ctrl.stKind = stNone;
				endcase
			end
			opLui:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.srcA = srcZero;
				imm = uImm;
			end
			opAuipc:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.srcA = srcPc;
				imm = uImm;
			end
			opOp:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.srcB = srcRs2;
				ctrl.aluOp = aluSelect(funct3, instr[30]);
				ctrl.wbSel = (funct3[2:1] == 2'b01) ? wbLess : wbAlu;
			end
			opOpImm:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluSelect(funct3, instr[30] && funct3 == 3'b101); // No SUBI
				ctrl.wbSel = (funct3[2:1] == 2'b01) ? wbLess : wbAlu;
				imm = (funct3[1:0] == 2'b01) ? shImm : iImm;
			end
			opBranch:
			begin
				ctrl.srcB = srcRs2;
				ctrl.aluOp = funct3[1] ? aluSubU : aluSub; // BLTU and BGEU
				imm = bImm;
				case (funct3)
					3'b000: ctrl.brKind = brEq;
					3'b001: ctrl.brKind = brNe;
					3'b100, 3'b110: ctrl.brKind = brLt;
					3'b101, 3'b111: ctrl.brKind = brGe;
					default: ctrl.brKind = brNone;
				endcase
			end
			opJal:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.srcA = srcPc;
				ctrl.srcB = srcFour; // Link value pc + 4
				ctrl.jal = 1'b1;
				imm = jImm;
			end
			opJalr:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.srcA = srcPc;
				ctrl.srcB = srcFour;
				ctrl.jalr = 1'b1;
			end
			opSystem: ; // Halt is picked up by the FSM
			default: knownOp = 1'b0;
		endcase
		if (hold)
		begin
			ctrl.brKind = brNone; // No redirect outside execute
			ctrl.jal = 1'b0;
			ctrl.jalr = 1'b0;
		end
	end

	always_comb
	begin
		if (knownOp)
			assert final (!$isunknown(ctrl))
			else $error("decoder produced unknown control for opcode %b", instr[6:0]);
	end

endmodule

// File: src/aluUnit.sv
`timescale 1ns/1ps

module aluUnit
	import rvPkg::*;
(
	input logic [xlen-1:0] opA,
	input logic [xlen-1:0] opB,
	input aluOp_t op,
	output logic [xlen-1:0] result,
	output logic less,
	output logic zero
);

	logic [4:0] shamt;

	assign shamt = opB[4:0];

	always_comb
	begin
		case (op)
			aluAdd: result = opA + opB;
			aluSub, aluSubU: result = opA - opB;
			aluAnd: result = opA & opB;
			aluOr: result = opA | opB;
			aluXor: result = opA ^ opB;
			aluSll: result = opA << shamt;
			aluSrl: result = opA >> shamt;
			aluSra: result = $signed(opA) >>> shamt;
			default: result = opA + opB;
		endcase
	end

	// Feeds SLT/SLTU writeback and branch decisions
	assign less = op[3] ? ($signed(opA) < $signed(opB)) : (opA < opB);
	assign zero = (result == '0);

endmodule

// File: src/regFile.sv
`timescale 1ns/1ps

module regFile
	import rvPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic [4:0] rs1Addr,
	input logic [4:0] rs2Addr,
	input logic [4:0] rdAddr,
	input logic writeEn,
	input logic [xlen-1:0] rdData,
	output logic [xlen-1:0] rs1Data,
	output logic [xlen-1:0] rs2Data
);

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (writeEn && rdAddr != 5'd0) // x0 stays zero
			regs[rdAddr] <= rdData;
	end

	assign rs1Data = regs[rs1Addr];
	assign rs2Data = regs[rs2Addr];

	writeEnKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(writeEn))
		else $error("register write enable is unknown");

endmodule

// File: src/pcUnit.sv
`timescale 1ns/1ps

module pcUnit
	import rvPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic pcLoad,
	input ctrlWord_t ctrl,
	input logic [xlen-1:0] imm,
	input logic [xlen-1:0] rs1Data,
	input logic less,
	input logic zero,
	output logic [xlen-1:0] pc
);

	logic taken;
	logic jump;
	logic redirect;
	logic [xlen-1:0] jalrSum;
	logic [xlen-1:0] jumpPc;
	logic [xlen-1:0] target;

	always_comb
	begin
		case (ctrl.brKind)
			brEq: taken = zero;
			brNe: taken = !zero;
			brLt: taken = less;
			brGe: taken = !less;
			default: taken = 1'b0;
		endcase
	end

	assign jump = taken || ctrl.jal || ctrl.jalr;
	assign jalrSum = rs1Data + imm;
	assign jumpPc = ctrl.jalr ? {jalrSum[xlen-1:1], 1'b0} : pc + imm;

	// Controls are live only in execute, so the redirect waits here for writeback
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			pc <= '0;
			redirect <= 1'b0;
		end
		else if (pcLoad)
		begin
			pc <= redirect ? target : pc + 4;
			redirect <= 1'b0;
		end
		else if (jump)
			redirect <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (jump)
			target <= jumpPc;
	end

	pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
		else $error("pc %h is not word aligned", pc);

endmodule

// File: src/coreCtrl.sv
`timescale 1ns/1ps

module coreCtrl
	import rvPkg::*;
(
	input logic clk,
	input logic rstN,
	input ctrlWord_t ctrl,
	input logic [6:0] opcode,
	output coreState_t state,
	output logic irLoad,
	output logic decHold,
	output logic pcLoad,
	output logic regWriteEn,
	output logic dataRead,
	output logic dataWrite,
	output logic halted
);

	coreState_t nextState;
	logic memAccess;
	logic isSystem;

	assign memAccess = (ctrl.ldKind != ldNone) || (ctrl.stKind != stNone);
	assign isSystem = (opcode == opSystem);

	always_comb
	begin
		case (state)
			stFetch: nextState = stExec;
			stExec:
			begin
				if (isSystem)
					nextState = stExec; // Parks here once halted
				else
					nextState = memAccess ? stMem : stWrite;
			end
			stMem: nextState = stWrite;
			default: nextState = stFetch;
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= stFetch;
			halted <= 1'b0;
		end
		else
		begin
			state <= nextState;
			if (state == stExec && isSystem)
				halted <= 1'b1;
		end
	end

	assign irLoad = (state == stFetch);
	assign decHold = (state != stExec);
	assign pcLoad = (state == stWrite);
	assign regWriteEn = (state == stWrite) && ctrl.regWrite;
	assign dataRead = (state == stExec) && (ctrl.ldKind != ldNone);
	assign dataWrite = (state == stExec) && (ctrl.stKind != stNone);

	rdWrExclusive: assert property (@(posedge clk) disable iff (!rstN) !(dataRead && dataWrite))
		else $error("data read and write strobes overlap");

endmodule

// File: src/memAlign.sv
`timescale 1ns/1ps

module memAlign
	import rvPkg::*;
(
	input logic [1:0] addrLow,
	input stKind_t stKind,
	input ldKind_t ldKind,
	input logic [xlen-1:0] storeData,
	input logic [xlen-1:0] memRdData,
	output logic [3:0] byteEn,
	output logic [xlen-1:0] wrData,
	output logic [xlen-1:0] loadData
);

	logic [xlen-1:0] laneData;

	assign laneData = memRdData >> {addrLow, 3'b000}; // Addressed byte to lane 0

	always_comb
	begin
		case (stKind)
			stWord:
			begin
				wrData = storeData;
				byteEn = 4'b1111;
			end
			stHalf:
			begin
				wrData = {2{storeData[15:0]}};
				byteEn = addrLow[1] ? 4'b1100 : 4'b0011;
			end
			stByte:
			begin
				wrData = {4{storeData[7:0]}};
				byteEn = 4'b0001 << addrLow;
			end
			default:
			begin
				wrData = storeData;
				byteEn = 4'b0000;
			end
		endcase
	end

	always_comb
	begin
		case (ldKind)
			ldHalf: loadData = {{16{laneData[15]}}, laneData[15:0]};
			ldByte: loadData = {{24{laneData[7]}}, laneData[7:0]};
			ldHalfU: loadData = {16'b0, laneData[15:0]};
			ldByteU: loadData = {24'b0, laneData[7:0]};
			default: loadData = memRdData;
		endcase
	end

	always_comb
	begin
		if (stKind == stWord || ldKind == ldWord)
			assert final (addrLow == 2'b00) else $error("misaligned word access");
		if (stKind == stHalf || ldKind == ldHalf || ldKind == ldHalfU)
			assert final (!addrLow[0]) else $error("misaligned half access");
	end

endmodule

// File: src/rvCore.sv
`timescale 1ns/1ps

module rvCore
	import rvPkg::*;
(
	input logic clk,
	input logic rstN,
	output logic [xlen-1:0] pc,
	input logic [31:0] instr,
	output logic [xlen-1:0] dataAddr,
	output logic [xlen-1:0] dataWrData,
	output logic [3:0] dataByteEn,
	output logic dataRead,
	output logic dataWrite,
	input logic [xlen-1:0] dataRdData,
	output logic halted
);

	logic [31:0] ir;
	ctrlWord_t ctrl;
	logic [xlen-1:0] imm;
	coreState_t state;
	logic irLoad;
	logic decHold;
	logic pcLoad;
	logic regWriteEn;
	logic [xlen-1:0] rs1Data;
	logic [xlen-1:0] rs2Data;
	logic [xlen-1:0] opA;
	logic [xlen-1:0] opB;
	logic [xlen-1:0] aluResult;
	logic less;
	logic zero;
	logic [xlen-1:0] loadData;
	logic [xlen-1:0] loadReg;
	logic [xlen-1:0] wbData;
	ldKind_t alignLd;
	stKind_t alignSt;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			ir <= '0;
		else if (irLoad)
			ir <= instr;
	end

	always_ff @(posedge clk)
	begin
		if (state == stMem)
			loadReg <= loadData; // Read data is valid during stMem
	end

	assign opA = (ctrl.srcA == srcPc) ? pc : (ctrl.srcA == srcRs1) ? rs1Data : '0;
	assign opB = (ctrl.srcB == srcImm) ? imm : (ctrl.srcB == srcFour) ? 32'd4 : rs2Data;
	assign wbData = (ctrl.wbSel == wbLoad) ? loadReg :
		(ctrl.wbSel == wbLess) ? {{(xlen-1){1'b0}}, less} : aluResult;

	// The IR is stale while fetching, so no access is in flight
	assign alignLd = (state == stFetch) ? ldNone : ctrl.ldKind;
	assign alignSt = (state == stFetch) ? stNone : ctrl.stKind;
	assign dataAddr = aluResult;

	riscvDecode decoder (.instr(ir), .hold(decHold), .ctrl(ctrl), .imm(imm));

	aluUnit alu (.opA(opA), .opB(opB), .op(ctrl.aluOp), .result(aluResult),
		.less(less), .zero(zero));

	regFile regs (.clk(clk), .rstN(rstN), .rs1Addr(ir[19:15]), .rs2Addr(ir[24:20]),
		.rdAddr(ir[11:7]), .writeEn(regWriteEn), .rdData(wbData),
		.rs1Data(rs1Data), .rs2Data(rs2Data));

	pcUnit pcGen (.clk(clk), .rstN(rstN), .pcLoad(pcLoad), .ctrl(ctrl), .imm(imm),
		.rs1Data(rs1Data), .less(less), .zero(zero), .pc(pc));

	coreCtrl fsm (.clk(clk), .rstN(rstN), .ctrl(ctrl), .opcode(ir[6:0]), .state(state),
		.irLoad(irLoad), .decHold(decHold), .pcLoad(pcLoad), .regWriteEn(regWriteEn),
		.dataRead(dataRead), .dataWrite(dataWrite), .halted(halted));

	memAlign aligner (.addrLow(aluResult[1:0]), .stKind(alignSt), .ldKind(alignLd),
		.storeData(rs2Data), .memRdData(dataRdData), .byteEn(dataByteEn),
		.wrData(dataWrData), .loadData(loadData));

endmodule

// File: test/coreTasks.svh
`ifndef CORE_TASKS_SVH
`define CORE_TASKS_SVH

function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, opOp};
endfunction

function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [2:0] f3);
	return {imm[11:5], rs2, 5'd0, f3, imm[4:0], opStore}; // Base is x0
endfunction

function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
endfunction

function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
endfunction

function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
	input logic [31:0] b);
	case (f3)
		3'b000: return a == b;
		3'b001: return a != b;
		3'b100: return $signed(a) < $signed(b);
		3'b101: return $signed(a) >= $signed(b);
		3'b110: return a < b;
		default: return a >= b;
	endcase
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
	begin
		$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		$display("Test FAILED");
		$fatal(1);
	end
endtask

task automatic stepCycle();
	@(posedge clk);
	#1;
endtask

task automatic clearProgram();
	for (int i = 0; i < 64; i++)
		imem[i] = 32'h00100073; // EBREAK everywhere
	progLen = 0;
endtask

task automatic clearDmem();
	for (int i = 0; i < 64; i++)
	begin
		dmem[i] = '0;
		expWords[i] = '0;
	end
endtask

task automatic emit(input logic [31:0] word);
	imem[progLen] = word;
	progLen++;
endtask

task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
	logic [31:0] upper;
	upper = value + 32'h800; // Compensates the sign of the ADDI part
	emit({upper[31:12], rd, opLui});
	emit(encI(value[11:0], rd, 3'b000, rd, opOpImm));
endtask

task automatic storeWord(input logic [4:0] rs2, input logic [11:0] addr);
	emit(encS(addr, rs2, 3'b010));
endtask

task automatic applyReset();
	rstN = 1'b0;
	for (int i = 0; i < 4; i++)
	begin
		stepCycle();
		check("halted in reset", {31'b0, halted}, 32'd0);
		check("dataWrite in reset", {31'b0, dataWrite}, 32'd0);
	end
	rstN = 1'b1;
endtask

task automatic runProgram();
	int n;
	emit(32'h00100073);
	for (int i = 0; i < 64; i++)
		dmem[i] = '0;
	applyReset();
	n = 0;
	while (!halted && n < 500)
	begin
		stepCycle();
		n++;
	end
	if (!halted)
	begin
		$display("Core did not halt within 500 cycles");
		$display("Test FAILED");
		$fatal(1);
	end
endtask

task automatic compareMem(input int count);
	for (int i = 0; i < count; i++)
		check($sformatf("dmem[%0d]", i), dmem[i], expWords[i]);
endtask

task automatic aluR(input logic [6:0] f7, input logic [2:0] f3, input int slot,
	input logic [31:0] exp);
	emit(encR(f7, 5'd2, 5'd1, f3, 5'd3));
	storeWord(5'd3, 12'(slot * 4));
	expWords[slot] = exp;
endtask

task automatic aluI(input logic [11:0] immField, input logic [2:0] f3, input int slot,
	input logic [31:0] exp);
	emit(encI(immField, 5'd1, f3, 5'd3, opOpImm));
	storeWord(5'd3, 12'(slot * 4));
	expWords[slot] = exp;
endtask

task automatic aluTest();
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] iv;
	logic [31:0] immS;
	logic [4:0] sh;
	a = $random(seed);
	b = $random(seed);
	iv = $random(seed);
	immS = {{20{iv[11]}}, iv[11:0]};
	sh = iv[4:0];
	clearProgram();
	clearDmem();
	loadConst(5'd1, a);
	loadConst(5'd2, b);
	aluR(7'h00, 3'b000, 0, a + b);
	aluR(7'h20, 3'b000, 1, a - b);
	aluR(7'h00, 3'b111, 2, a & b);
	aluR(7'h00, 3'b110, 3, a | b);
	aluR(7'h00, 3'b100, 4, a ^ b);
	aluR(7'h00, 3'b001, 5, a << b[4:0]);
	aluR(7'h00, 3'b101, 6, a >> b[4:0]);
	aluR(7'h20, 3'b101, 7, $signed(a) >>> b[4:0]);
	aluR(7'h00, 3'b010, 8, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
	aluR(7'h00, 3'b011, 9, (a < b) ? 32'd1 : 32'd0);
	aluI(iv[11:0], 3'b000, 10, a + immS);
	aluI(iv[11:0], 3'b111, 11, a & immS);
	aluI(iv[11:0], 3'b110, 12, a | immS);
	aluI(iv[11:0], 3'b100, 13, a ^ immS);
	aluI({7'h00, sh}, 3'b001, 14, a << sh);
	aluI({7'h00, sh}, 3'b101, 15, a >> sh);
	aluI({7'h20, sh}, 3'b101, 16, $signed(a) >>> sh);
	aluI(iv[11:0], 3'b010, 17, ($signed(a) < $signed(immS)) ? 32'd1 : 32'd0);
	aluI(iv[11:0], 3'b011, 18, (a < immS) ? 32'd1 : 32'd0);
	runProgram();
	compareMem(19);
endtask

task automatic upperTest();
	logic [31:0] auipcAddr;
	clearProgram();
	clearDmem();
	emit({20'hABCDE, 5'd3, opLui});
	auipcAddr = 32'(progLen * 4);
	emit({20'h12345, 5'd4, opAuipc});
	storeWord(5'd3, 12'h000);
	storeWord(5'd4, 12'h004);
	expWords[0] = 32'hABCDE000;
	expWords[1] = 32'h12345000 + auipcAddr;
	runProgram();
	compareMem(2);
endtask

task automatic memTest();
	logic [7:0] b1;
	logic [15:0] h2;
	clearProgram();
	clearDmem();
	b1 = 8'hF3;
	h2 = 16'h8E71;
	loadConst(5'd1, 32'h123456F3);
	loadConst(5'd2, 32'hABCD8E71);
	emit(encS(12'h010, 5'd1, 3'b000)); // SB lane 0
	emit(encS(12'h011, 5'd1, 3'b000)); // SB lane 1
	emit(encS(12'h012, 5'd2, 3'b001)); // SH upper half
	emit(encS(12'h017, 5'd1, 3'b000)); // SB lane 3 of next word
	emit(encI(12'h011, 5'd0, 3'b000, 5'd3, opLoad));
	emit(encI(12'h011, 5'd0, 3'b100, 5'd4, opLoad));
	emit(encI(12'h012, 5'd0, 3'b001, 5'd5, opLoad));
	emit(encI(12'h012, 5'd0, 3'b101, 5'd6, opLoad));
	emit(encI(12'h010, 5'd0, 3'b010, 5'd7, opLoad));
	emit(encI(12'h010, 5'd0, 3'b001, 5'd8, opLoad));
	for (int r = 3; r <= 8; r++)
		storeWord(5'(r), 12'((r + 5) * 4));
	expWords[4] = {h2, b1, b1};
	expWords[5] = {b1, 24'h0};
	expWords[8] = {{24{b1[7]}}, b1};
	expWords[9] = {24'h0, b1};
	expWords[10] = {{16{h2[15]}}, h2};
	expWords[11] = {16'h0, h2};
	expWords[12] = {h2, b1, b1};
	expWords[13] = {{16{b1[7]}}, b1, b1};
	runProgram();
	compareMem(14);
endtask

task automatic branchCase(input int i, input logic [2:0] f3, input logic [4:0] rs1,
	input logic [4:0] rs2, input logic [31:0] a, input logic [31:0] b);
	emit(encB(13'd12, rs2, rs1, f3));
	emit(encI(12'(12'h200 + i), 5'd0, 3'b000, 5'd9, opOpImm)); // Fall-through marker
	emit(encJ(21'd8, 5'd0));
	emit(encI(12'(12'h100 + i), 5'd0, 3'b000, 5'd9, opOpImm)); // Taken marker
	storeWord(5'd9, 12'(i * 4));
	expWords[i] = branchTaken(f3, a, b) ? 32'h100 + i : 32'h200 + i;
endtask

task automatic branchTest();
	logic [31:0] neg;
	logic [31:0] pos;
	neg = 32'hFFFFFFFB;
	pos = 32'd3;
	clearProgram();
	clearDmem();
	loadConst(5'd1, neg);
	loadConst(5'd2, pos);
	branchCase(0, 3'b000, 5'd1, 5'd1, neg, neg);
	branchCase(1, 3'b000, 5'd1, 5'd2, neg, pos);
	branchCase(2, 3'b001, 5'd1, 5'd2, neg, pos);
	branchCase(3, 3'b100, 5'd1, 5'd2, neg, pos);
	branchCase(4, 3'b101, 5'd1, 5'd2, neg, pos);
	branchCase(5, 3'b110, 5'd1, 5'd2, neg, pos);
	branchCase(6, 3'b111, 5'd1, 5'd2, neg, pos);
	branchCase(7, 3'b100, 5'd2, 5'd1, pos, neg);
	branchCase(8, 3'b101, 5'd2, 5'd1, pos, neg);
	branchCase(9, 3'b110, 5'd2, 5'd1, pos, neg);
	branchCase(10, 3'b111, 5'd2, 5'd1, pos, neg);
	runProgram();
	compareMem(11);
endtask

task automatic jumpTest();
	logic [31:0] jalAddr;
	logic [31:0] target;
	logic [31:0] retAddr;
	clearProgram();
	clearDmem();
	loadConst(5'd5, 32'h55);
	jalAddr = 32'(progLen * 4);
	emit(encJ(21'd8, 5'd1));
	storeWord(5'd5, 12'h000); // Skipped by JAL
	storeWord(5'd1, 12'h004);
	target = 32'((progLen + 4) * 4);
	retAddr = 32'((progLen + 3) * 4);
	loadConst(5'd6, target);
	emit(encI(12'd1, 5'd6, 3'b000, 5'd7, opJalr)); // Bit 0 of the sum is dropped
	storeWord(5'd5, 12'h008); // Skipped by JALR
	storeWord(5'd7, 12'h00C);
	expWords[1] = jalAddr + 4;
	expWords[3] = retAddr;
	runProgram();
	compareMem(4);
endtask

task automatic haltTest();
	int edges;
	clearProgram();
	clearDmem();
	for (int i = 0; i < 5; i++)
		emit(encI(12'd1, 5'd1, 3'b000, 5'd1, opOpImm));
	emit(32'h00100073);
	storeWord(5'd1, 12'h000); // Lies past the halt
	edges = 5 * 3 + 2; // Three cycles each, then EBREAK fetch and execute
	applyReset();
	for (int k = 1; k <= edges + 10; k++)
	begin
		stepCycle();
		check($sformatf("halted at edge %0d", k), {31'b0, halted},
			(k >= edges) ? 32'd1 : 32'd0);
		check("dataWrite", {31'b0, dataWrite}, 32'd0);
	end
	compareMem(1);
	applyReset();
endtask

`endif

// File: test/coreTb.sv
`timescale 1ns/1ps

module coreTb
	import rvPkg::*;
();

	logic clk;
	logic rstN;
	logic [31:0] pc;
	logic [31:0] instr;
	logic [31:0] dataAddr;
	logic [31:0] dataWrData;
	logic [3:0] dataByteEn;
	logic dataRead;
	logic dataWrite;
	logic [31:0] dataRdData;
	logic halted;

	logic [31:0] imem [64];
	logic [31:0] dmem [64];
	logic [31:0] expWords [64];
	int progLen;
	integer seed;
	logic rdPend;
	logic [5:0] rdIdx;

	rvCore UUT (.clk(clk), .rstN(rstN), .pc(pc), .instr(instr), .dataAddr(dataAddr),
		.dataWrData(dataWrData), .dataByteEn(dataByteEn), .dataRead(dataRead),
		.dataWrite(dataWrite), .dataRdData(dataRdData), .halted(halted));

	always #2 clk = ~clk;

	assign instr = imem[pc[7:2]]; // Combinational fetch

	// Data port sampled mid-cycle, away from the clock edge
	always @(negedge clk)
	begin
		if (dataWrite)
		begin
			for (int i = 0; i < 4; i++)
				if (dataByteEn[i])
					dmem[dataAddr[7:2]][8*i +: 8] = dataWrData[8*i +: 8];
		end
		if (dataRead)
		begin
			rdPend = 1'b1;
			rdIdx = dataAddr[7:2];
		end
	end

	always @(posedge clk)
	begin
		#1;
		if (rdPend)
		begin
			dataRdData = dmem[rdIdx]; // Valid through stMem
			rdPend = 1'b0;
		end
	end

	`include "coreTasks.svh"

	initial
	begin
		clk = 1'b0;
		rstN = 1'b0;
		dataRdData = '0;
		rdPend = 1'b0;
		rdIdx = '0;
		seed = 32'h522b;
		clearProgram();
		clearDmem();
		aluTest();
		upperTest();
		memTest();
		branchTest();
		jumpTest();
		haltTest();
		$display("Test OK");
		$finish;
	end

endmodule

// File: all.f
+incdir+test
src/rvPkg.sv
src/riscvDecode.sv
src/aluUnit.sv
src/regFile.sv
src/pcUnit.sv
src/coreCtrl.sv
src/memAlign.sv
src/rvCore.sv
test/coreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= coreTb
FLIST ?= all.f
BUILD ?= obj_dir
VFLAGS ?= --timing --assert
PASS ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FLIST) src/*.sv test/*.sv test/*.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS)"

clean:
	rm -rf $(BUILD)
